// ==== hdl/mvu_pkg.sv ====
//****************************************************************************
// Matrix-vector lane package
// Widths, memory depths and shared types of the bit-serial dot-product lane
//****************************************************************************

package mvu_pkg;

    localparam int N_LANE         = 8;    // Vector elements, also plane width
    localparam int W_DEPTH        = 16;   // Weight memory depth
    localparam int D_DEPTH        = 32;   // Input memory depth
    localparam int MEM_RD_LATENCY = 1;    // Registered memory read

    localparam int BPREC    = 3;          // Precision field holds precision minus 1
    localparam int ACC_W    = 20;         // Accumulator
    localparam int BSCALERB = 16;         // Scaler operand
    localparam int PROD_W   = 36;         // Scaled product
    localparam int QUANT_W  = 8;          // Quantized result
    localparam int BQMSBIDX = 6;          // Quantizer MSB index

    // Busy cycles after the last issue, read + accumulate + multiply
    localparam int TAIL_CYC = MEM_RD_LATENCY + 2;

    typedef logic [N_LANE-1:0]                  plane_t;   // One bit plane
    typedef logic [BPREC-1:0]                   prec_t;    // Precision field
    typedef logic [$clog2(W_DEPTH)-1:0]         waddr_t;   // Weight address
    typedef logic [$clog2(D_DEPTH)-1:0]         daddr_t;   // Input address
    typedef logic signed [ACC_W-1:0]            acc_t;     // Dot-product sum
    typedef logic signed [BSCALERB-1:0]         scaler_t;  // Scaler
    typedef logic signed [PROD_W-1:0]           prod_t;    // Sum times scaler
    typedef logic [QUANT_W-1:0]                 quant_t;   // Result window
    typedef logic [BQMSBIDX-1:0]                msbidx_t;  // Window MSB position
    typedef logic [3:0]                         shift_t;   // Input bit + weight bit
    typedef logic [$clog2(N_LANE+1)-1:0]        cnt_t;     // Ones count of a plane
    typedef logic [$clog2(TAIL_CYC)-1:0]        tail_t;    // Drain counter

endpackage

// ==== hdl/plane_if.sv ====
//****************************************************************************
// Bit-plane pair issue bus
// One pair per cycle from the job decoder to the bit-serial MAC
//****************************************************************************

`timescale 1ns/1ps

interface plane_if;
    import mvu_pkg::*;

    logic   valid;    // Pair issued this cycle
    logic   first;    // First pair of the job
    logic   last;     // Last pair of the job
    logic   neg;      // Term is subtracted
    shift_t shift;    // Combined bit weight

    modport issue (
        output valid, first, last, neg, shift
    );

    modport execute (
        input  valid, first, last, neg, shift
    );

endinterface

// ==== hdl/job_decode.sv ====
//****************************************************************************
// Job decoder
// Latches the job on start and walks all input/weight bit pairs MSB first
//****************************************************************************

`timescale 1ns/1ps

module job_decode (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,          // Job request
    input  logic             d_signed,       // Inputs are two's complement
    input  logic             w_signed,       // Weights are two's complement
    input  mvu_pkg::prec_t   iprecision,     // Input bits minus 1
    input  mvu_pkg::prec_t   wprecision,     // Weight bits minus 1
    input  mvu_pkg::daddr_t  ibaseaddr,      // Input plane of bit 0
    input  mvu_pkg::waddr_t  wbaseaddr,      // Weight plane of bit 0
    input  mvu_pkg::scaler_t scaler_b,
    input  mvu_pkg::msbidx_t quant_msbidx,
    output logic             busy,
    output mvu_pkg::daddr_t  i_addr,         // Input memory read address
    output mvu_pkg::waddr_t  w_addr,         // Weight memory read address
    output mvu_pkg::scaler_t scaler_q,       // Latched scaler for the result stage
    output mvu_pkg::msbidx_t msbidx_q,       // Latched window MSB
    plane_if.issue           pl
);
    import mvu_pkg::*;

    logic   accept;
    logic   issuing;
    logic   d_signed_q;
    logic   w_signed_q;
    prec_t  iprec_q;
    prec_t  wprec_q;
    daddr_t ibase_q;
    waddr_t wbase_q;
    prec_t  ibit;
    prec_t  wbit;
    tail_t  tail;
    logic   i_msb;
    logic   w_msb;

    assign accept = start & ~busy;                   // Start ignored mid-job

    // Job configuration, held for the whole job
    always_ff @(posedge clk) begin
        if (accept) begin
            d_signed_q <= d_signed;
            w_signed_q <= w_signed;
            iprec_q    <= iprecision;
            wprec_q    <= wprecision;
            ibase_q    <= ibaseaddr;
            wbase_q    <= wbaseaddr;
            scaler_q   <= scaler_b;
            msbidx_q   <= quant_msbidx;
        end
    end

    // Outer loop on input bit, inner loop on weight bit, then drain
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            issuing <= 1'b0;
            ibit    <= '0;
            wbit    <= '0;
            tail    <= '0;
        end else if (accept) begin
            busy    <= 1'b1;
            issuing <= 1'b1;
            ibit    <= iprecision;                   // Start on both MSBs
            wbit    <= wprecision;
        end else if (issuing) begin
            if (wbit != '0) begin
                wbit <= wbit - prec_t'(1);
            end else if (ibit != '0) begin
                ibit <= ibit - prec_t'(1);           // Next input bit
                wbit <= wprec_q;                     // Restart weight bits
            end else begin
                issuing <= 1'b0;                     // Last pair issued
                tail    <= tail_t'(TAIL_CYC - 1);
            end
        end else if (busy) begin
            if (tail == '0) begin
                busy <= 1'b0;                        // Falls as done rises
            end else begin
                tail <= tail - tail_t'(1);
            end
        end
    end

    assign i_msb = (ibit == iprec_q);
    assign w_msb = (wbit == wprec_q);

    assign pl.valid = issuing;
    assign pl.first = issuing & i_msb & w_msb;
    assign pl.last  = issuing & (ibit == '0) & (wbit == '0);
    assign pl.neg   = (d_signed_q & i_msb) ^ (w_signed_q & w_msb);  // Exactly one signed MSB
    assign pl.shift = shift_t'(ibit) + shift_t'(wbit);

    assign i_addr = ibase_q + daddr_t'(ibit);        // Plane of bit b at base + b
    assign w_addr = wbase_q + waddr_t'(wbit);

endmodule

// ==== hdl/plane_ram.sv ====
//****************************************************************************
// Bit-plane memory
// One write port, one registered read port
//****************************************************************************

`timescale 1ns/1ps

module plane_ram #(
    parameter int DEPTH = 16                         // Number of planes
) (
    input  logic                     clk,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  mvu_pkg::plane_t          wr_word,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output mvu_pkg::plane_t          rd_word        // Valid one cycle after rd_addr
);
    import mvu_pkg::*;

    plane_t mem [DEPTH];                             // Contents undefined until written

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_word;                 // Host write
        end
        rd_word <= mem[rd_addr];                     // Read every cycle
    end

endmodule

// ==== hdl/bitserial_mac.sv ====
//****************************************************************************
// Bit-serial multiply-accumulate
// AND and popcount of each plane pair, weighted, signed and summed
//****************************************************************************

`timescale 1ns/1ps

module bitserial_mac (
    input  logic            clk,
    input  logic            rst_n,
    input  mvu_pkg::plane_t i_plane,                 // Input plane from memory
    input  mvu_pkg::plane_t w_plane,                 // Weight plane from memory
    plane_if.execute        pl,
    output logic            acc_valid,               // Sum complete, one cycle
    output mvu_pkg::acc_t   acc
);
    import mvu_pkg::*;

    // Controls delayed to meet the planes out of memory
    logic   valid_d [MEM_RD_LATENCY];
    logic   first_d [MEM_RD_LATENCY];
    logic   last_d  [MEM_RD_LATENCY];
    logic   neg_d   [MEM_RD_LATENCY];
    shift_t shift_d [MEM_RD_LATENCY];

    plane_t and_plane;
    cnt_t   cnt;
    acc_t   shifted;
    acc_t   term;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < MEM_RD_LATENCY; i++) begin
                valid_d[i] <= 1'b0;
                first_d[i] <= 1'b0;
                last_d[i]  <= 1'b0;
            end
        end else begin
            valid_d[0] <= pl.valid;
            first_d[0] <= pl.first;
            last_d[0]  <= pl.last;
            for (int i = 1; i < MEM_RD_LATENCY; i++) begin
                valid_d[i] <= valid_d[i-1];
                first_d[i] <= first_d[i-1];
                last_d[i]  <= last_d[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        neg_d[0]   <= pl.neg;
        shift_d[0] <= pl.shift;
        for (int i = 1; i < MEM_RD_LATENCY; i++) begin
            neg_d[i]   <= neg_d[i-1];
            shift_d[i] <= shift_d[i-1];
        end
    end

    assign and_plane = i_plane & w_plane;            // 1-bit products of all lanes

    always_comb begin
        cnt = '0;
        for (int i = 0; i < N_LANE; i++) begin
            cnt = cnt + cnt_t'(and_plane[i]);        // Popcount
        end
    end

    assign shifted = acc_t'(cnt) << shift_d[MEM_RD_LATENCY-1];      // Weight 2^(i+j)
    assign term    = neg_d[MEM_RD_LATENCY-1] ? -shifted : shifted;  // Signed MSB term

    always_ff @(posedge clk) begin
        if (valid_d[MEM_RD_LATENCY-1]) begin
            if (first_d[MEM_RD_LATENCY-1]) begin
                acc <= term;                         // New job overwrites old sum
            end else begin
                acc <= acc + term;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc_valid <= 1'b0;
        end else begin
            acc_valid <= valid_d[MEM_RD_LATENCY-1] & last_d[MEM_RD_LATENCY-1];
        end
    end

endmodule

// ==== hdl/scale_quant.sv ====
//****************************************************************************
// Result stage
// Scales the finished sum and cuts an 8-bit window ending at the MSB index
//****************************************************************************

`timescale 1ns/1ps

module scale_quant (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             acc_valid,              // Sum ready
    input  mvu_pkg::acc_t    acc,
    input  mvu_pkg::scaler_t scaler_b,
    input  mvu_pkg::msbidx_t quant_msbidx,           // Product bit that lands on result MSB
    output logic             done,                   // Result valid, one cycle
    output mvu_pkg::quant_t  result
);
    import mvu_pkg::*;

    logic                             prod_valid;
    prod_t                            prod_q;
    logic signed [PROD_W+QUANT_W-2:0] prod_ext;      // Product with zero bits below bit 0
    quant_t                           window;

    // Multiply stage
    always_ff @(posedge clk) begin
        if (acc_valid) begin
            prod_q <= acc * scaler_b;                // Signed 20 x 16
        end
    end

    assign prod_ext = {prod_q, {(QUANT_W-1){1'b0}}};

    // Bits msbidx down to msbidx-7, sign fills above the product MSB
    assign window = quant_t'(prod_ext >>> quant_msbidx);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
            done       <= 1'b0;
            result     <= '0;
        end else begin
            prod_valid <= acc_valid;
            done       <= prod_valid;                // Quantize stage
            if (prod_valid) begin
                result <= window;                    // Held until the next job
            end
        end
    end

endmodule

// ==== hdl/mvu_top.sv ====
//****************************************************************************
// Matrix-vector lane top
// Job decode, weight and input plane memories, MAC and result stage
//****************************************************************************

`timescale 1ns/1ps

module mvu_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,                  // Honoured only while idle
    input  logic             d_signed,
    input  logic             w_signed,
    input  mvu_pkg::prec_t   iprecision,
    input  mvu_pkg::prec_t   wprecision,
    input  mvu_pkg::daddr_t  ibaseaddr,
    input  mvu_pkg::waddr_t  wbaseaddr,
    input  mvu_pkg::scaler_t scaler_b,
    input  mvu_pkg::msbidx_t quant_msbidx,
    input  logic             wrw_en,                 // Weight memory write
    input  mvu_pkg::waddr_t  wrw_addr,
    input  mvu_pkg::plane_t  wrw_word,
    input  logic             wrd_en,                 // Input memory write
    input  mvu_pkg::daddr_t  wrd_addr,
    input  mvu_pkg::plane_t  wrd_word,
    output logic             busy,
    output logic             done,
    output mvu_pkg::quant_t  result
);
    import mvu_pkg::*;

    daddr_t  i_addr;
    waddr_t  w_addr;
    plane_t  i_plane;
    plane_t  w_plane;
    scaler_t scaler_q;
    msbidx_t msbidx_q;
    logic    acc_valid;
    acc_t    acc;

    plane_if pl ();                                  // Decode to MAC issue bus

    job_decode u_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .d_signed     (d_signed),
        .w_signed     (w_signed),
        .iprecision   (iprecision),
        .wprecision   (wprecision),
        .ibaseaddr    (ibaseaddr),
        .wbaseaddr    (wbaseaddr),
        .scaler_b     (scaler_b),
        .quant_msbidx (quant_msbidx),
        .busy         (busy),
        .i_addr       (i_addr),
        .w_addr       (w_addr),
        .scaler_q     (scaler_q),
        .msbidx_q     (msbidx_q),
        .pl           (pl.issue)
    );

    plane_ram #(.DEPTH(W_DEPTH)) u_wmem (
        .clk     (clk),
        .wr_en   (wrw_en),
        .wr_addr (wrw_addr),
        .wr_word (wrw_word),
        .rd_addr (w_addr),
        .rd_word (w_plane)
    );

    plane_ram #(.DEPTH(D_DEPTH)) u_dmem (
        .clk     (clk),
        .wr_en   (wrd_en),
        .wr_addr (wrd_addr),
        .wr_word (wrd_word),
        .rd_addr (i_addr),
        .rd_word (i_plane)
    );

    bitserial_mac u_mac (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_plane   (i_plane),
        .w_plane   (w_plane),
        .pl        (pl.execute),
        .acc_valid (acc_valid),
        .acc       (acc)
    );

    scale_quant u_result (
        .clk          (clk),
        .rst_n        (rst_n),
        .acc_valid    (acc_valid),
        .acc          (acc),
        .scaler_b     (scaler_q),                    // Latched copies from the decoder
        .quant_msbidx (msbidx_q),
        .done         (done),
        .result       (result)
    );

endmodule

// ==== dv/mvu_tb.sv ====
//****************************************************************************
// Matrix-vector lane testbench
// Random dot-product jobs from a fixed seed, checked against a software model
//****************************************************************************

`timescale 1ns/1ps

module mvu_tb;
    import mvu_pkg::*;

    localparam int JOB_TIMEOUT = 200;                // Negedges allowed for one job
    localparam int SEED        = 48524;

    logic    clk;
    logic    rst_n;
    logic    start;
    logic    d_signed;
    logic    w_signed;
    prec_t   iprecision;
    prec_t   wprecision;
    daddr_t  ibaseaddr;
    waddr_t  wbaseaddr;
    scaler_t scaler_b;
    msbidx_t quant_msbidx;
    logic    wrw_en;
    waddr_t  wrw_addr;
    plane_t  wrw_word;
    logic    wrd_en;
    daddr_t  wrd_addr;
    plane_t  wrd_word;
    logic    busy;
    logic    done;
    quant_t  result;

    plane_t  dmem_sh [D_DEPTH];                      // Shadow of the input memory
    plane_t  wmem_sh [W_DEPTH];                      // Shadow of the weight memory
    int      err_cnt;
    int      job_cnt;

    mvu_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .d_signed     (d_signed),
        .w_signed     (w_signed),
        .iprecision   (iprecision),
        .wprecision   (wprecision),
        .ibaseaddr    (ibaseaddr),
        .wbaseaddr    (wbaseaddr),
        .scaler_b     (scaler_b),
        .quant_msbidx (quant_msbidx),
        .wrw_en       (wrw_en),
        .wrw_addr     (wrw_addr),
        .wrw_word     (wrw_word),
        .wrd_en       (wrd_en),
        .wrd_addr     (wrd_addr),
        .wrd_word     (wrd_word),
        .busy         (busy),
        .done         (done),
        .result       (result)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                      // 20 ns period
    end

    task automatic stop_on_error();
        err_cnt++;
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic abort_run(input string msg);
        $display("Run aborted at %0t ns: %s", $time, msg);
        stop_on_error();
    endtask

    task automatic check_result(input quant_t got, input quant_t exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s got 0x%02h, expected 0x%02h", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            $display("** Error at %0t ns: done after %0d cycles, expected %0d", $time, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    // Element e rebuilt from prec planes starting at base, MSB weighs -2^(prec-1) if signed
    function automatic int element_value(input bit is_dmem, input int base, input int prec,
                                         input bit sgn, input int e);
        int     val;
        plane_t plane;
        val = 0;
        for (int b = 0; b < prec; b++) begin
            if (is_dmem) begin
                plane = dmem_sh[daddr_t'(base + b)];  // Address wraps like the DUT's
            end else begin
                plane = wmem_sh[waddr_t'(base + b)];
            end
            if (plane[e]) begin
                if (sgn && b == prec - 1) begin
                    val -= (1 << b);
                end else begin
                    val += (1 << b);
                end
            end
        end
        return val;
    endfunction

    // Dot product, scaled, then bits msbidx down to msbidx-7 of the product
    function automatic quant_t expected_result();
        longint dot;
        longint prod;
        longint xv;
        longint wv;
        int     pos;
        quant_t q;
        dot = 0;
        for (int e = 0; e < N_LANE; e++) begin
            xv  = longint'(element_value(1'b1, int'(ibaseaddr), int'(iprecision) + 1, d_signed, e));
            wv  = longint'(element_value(1'b0, int'(wbaseaddr), int'(wprecision) + 1, w_signed, e));
            dot += xv * wv;
        end
        prod = dot * longint'(scaler_b);             // Sign bits fill above bit 35
        for (int k = 0; k < QUANT_W; k++) begin
            pos  = int'(quant_msbidx) - (QUANT_W - 1) + k;
            q[k] = (pos < 0) ? 1'b0 : prod[pos];     // Below bit 0 reads as 0
        end
        return q;
    endfunction

    task automatic random_config(input bit ds, input bit ws);
        @(negedge clk);
        d_signed     = ds;
        w_signed     = ws;
        iprecision   = prec_t'($urandom);
        wprecision   = prec_t'($urandom);
        ibaseaddr    = daddr_t'($urandom);
        wbaseaddr    = waddr_t'($urandom);
        scaler_b     = scaler_t'($urandom);
        quant_msbidx = msbidx_t'($urandom_range(30, 7));  // Window inside the busy bits
    endtask

    // Random planes for every bit the current job reads, memories written while idle
    task automatic load_planes();
        for (int b = 0; b <= int'(iprecision); b++) begin
            @(negedge clk);
            wrd_en   = 1'b1;
            wrd_addr = ibaseaddr + daddr_t'(b);
            wrd_word = plane_t'($urandom);
            dmem_sh[wrd_addr] = wrd_word;
        end
        for (int b = 0; b <= int'(wprecision); b++) begin
            @(negedge clk);
            wrd_en   = 1'b0;
            wrw_en   = 1'b1;
            wrw_addr = wbaseaddr + waddr_t'(b);
            wrw_word = plane_t'($urandom);
            wmem_sh[wrw_addr] = wrw_word;
        end
        @(negedge clk);
        wrd_en = 1'b0;
        wrw_en = 1'b0;
    endtask

    // Pulses start, counts negedges until done, optional second start at cycle repulse_at
    task automatic run_job(input int repulse_at, output quant_t res, output int cycles);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        @(negedge clk);
        start = 1'b1;
        while (!seen) begin
            @(negedge clk);
            n++;
            start = (n == repulse_at);               // Mid-job start must be ignored
            if (done) begin
                seen = 1'b1;
            end else begin
                check_flag(busy, 1'b1, "busy during job");
                if (n > JOB_TIMEOUT) begin
                    abort_run("timeout while waiting for done");
                end
            end
        end
        start = 1'b0;
        check_flag(busy, 1'b0, "busy on done");      // Falls on the done edge
        res    = result;
        cycles = n;
    endtask

    task automatic run_and_check(input int repulse_at);
        quant_t exp;
        quant_t got;
        int     cycles;
        int     p;
        exp = expected_result();
        p   = (int'(iprecision) + 1) * (int'(wprecision) + 1);
        run_job(repulse_at, got, cycles);
        check_result(got, exp, "job result");
        check_latency(cycles, p + 4);
        job_cnt++;
    endtask

    // No further done may follow a job
    task automatic expect_quiet(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            check_flag(done, 1'b0, "done after ignored start");
        end
    endtask

    initial begin
        int mi_list [10] = '{0, 3, 7, 12, 19, 28, 35, 36, 50, 63};
        err_cnt      = 0;
        job_cnt      = 0;
        rst_n        = 1'b0;
        start        = 1'b0;
        d_signed     = 1'b0;
        w_signed     = 1'b0;
        iprecision   = '0;
        wprecision   = '0;
        ibaseaddr    = '0;
        wbaseaddr    = '0;
        scaler_b     = '0;
        quant_msbidx = '0;
        wrw_en       = 1'b0;
        wrw_addr     = '0;
        wrw_word     = '0;
        wrd_en       = 1'b0;
        wrd_addr     = '0;
        wrd_word     = '0;
        void'($urandom(SEED));                       // Single seed for the whole run

        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        check_flag(done, 1'b0, "done after reset");
        check_flag(busy, 1'b0, "busy after reset");
        check_result(result, '0, "result after reset");

        repeat (20) begin                            // Unsigned jobs
            random_config(1'b0, 1'b0);
            load_planes();
            run_and_check(0);
        end

        for (int mode = 1; mode < 4; mode++) begin   // Signed inputs, weights, both
            repeat (10) begin
                random_config(mode[0], mode[1]);
                load_planes();
                run_and_check(0);
            end
        end

        random_config(1'b1, 1'b1);                   // One product, many windows
        load_planes();
        foreach (mi_list[i]) begin
            @(negedge clk);
            quant_msbidx = msbidx_t'(mi_list[i]);
            run_and_check(0);
        end

        random_config(1'b1, 1'b0);
        load_planes();
        run_and_check(2);                            // Start again while busy
        expect_quiet((int'(iprecision) + 1) * (int'(wprecision) + 1) + 8);

        if (err_cnt == 0) begin
            $display("%0d jobs checked", job_cnt);
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
hdl/mvu_pkg.sv
hdl/plane_if.sv
hdl/job_decode.sv
hdl/plane_ram.sv
hdl/bitserial_mac.sv
hdl/scale_quant.sv
hdl/mvu_top.sv
dv/mvu_tb.sv

// ==== Makefile ====
# Verilator build and run of the matrix-vector lane testbench

LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 -Wno-fatal --top-module mvu_tb -f compile.f

run: compile
	./obj_dir/Vmvu_tb 2>&1 | tee $(LOG)
	@grep -q "=== PASS ===" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
